// File: apb_bus_pkg.sv
/* APB bus package
   widths, payload types and the address word with its decoded views */
package apb_bus_pkg;

    // the bus is a plain 32-bit APB with byte strobes
    localparam int addr_width_c = 32;
    localparam int data_width_c = 32;
    localparam int strb_width_c = data_width_c / 8;

    typedef logic [addr_width_c-1:0] apb_addr_t;
    typedef logic [data_width_c-1:0] apb_data_t;
    typedef logic [strb_width_c-1:0] apb_strb_t;

    // every slot carries this many read/write registers
    // the identity register sits at the index right after them
    localparam int regs_per_slot_c = 3;

    // register select bits wide enough to reach the identity index as well
    localparam int reg_sel_width_c = $clog2(regs_per_slot_c + 1);

    // field view of an address inside the peripheral page
    // a slot window is 4 KiB, so the slot number starts at bit 12
    typedef struct packed {
        logic [16:0] page;
        logic [2:0]  slot;
        logic [9:0]  reg_idx;
        logic [1:0]  byte_off;
    } apb_addr_fields_t;

    // the same word seen two ways
    // raw feeds the window range compare, fields pick slot and register
    typedef union packed {
        apb_addr_t        raw;
        apb_addr_fields_t fields;
    } apb_addr_u;

endpackage

// File: periph_map_pkg.sv
/* peripheral map package
   window layout of the peripheral page and the per-slot access timing */
package periph_map_pkg;

    // five slots are populated, slot fields 5 to 7 stay unmapped
    localparam int num_slots_c = 5;

    // the peripheral page starts here and each slot owns one 4 KiB window
    localparam apb_bus_pkg::apb_addr_t periph_base_c = 32'h1A10_0000;
    localparam apb_bus_pkg::apb_addr_t slot_span_c   = 32'h0000_1000;

    // wait states a slot inserts before it raises ready in the access phase
    // one wait state gives a two cycle access phase
    localparam int slot_wait_c = 1;

    // the counter needs at least one bit even with zero wait states
    localparam int wait_cnt_width_c = (slot_wait_c > 0) ? $clog2(slot_wait_c + 1) : 1;

    typedef logic [wait_cnt_width_c-1:0] wait_cnt_t;

    // one bit per slot, at most one bit set
    typedef logic [num_slots_c-1:0] slot_sel_t;

endpackage

// File: apb_addr_decode.sv
/* APB address decoder
   maps the transfer address onto a one-hot slot select or flags it unmapped */
`timescale 1ns/1ps

module apb_addr_decode (
    input  apb_bus_pkg::apb_addr_t    paddr,
    input  logic                      psel,
    output periph_map_pkg::slot_sel_t slot_sel,
    output logic                      unmapped
);

    // address seen through the union, raw word and fields side by side
    apb_bus_pkg::apb_addr_u addr;

    // start and last byte of each slot window
    apb_bus_pkg::apb_addr_t [periph_map_pkg::num_slots_c-1:0] start_addr;
    apb_bus_pkg::apb_addr_t [periph_map_pkg::num_slots_c-1:0] end_addr;

    // range hit from the raw word and slot hit from the field view
    periph_map_pkg::slot_sel_t in_range;
    periph_map_pkg::slot_sel_t field_hit;
    periph_map_pkg::slot_sel_t match;

    assign addr.raw = paddr;

    // each window follows the previous one with no gap
    for (genvar i = 0; i < periph_map_pkg::num_slots_c; i++) begin : g_window
        assign start_addr[i] = periph_map_pkg::periph_base_c
                             + apb_bus_pkg::apb_addr_t'(i) * periph_map_pkg::slot_span_c;
        assign end_addr[i]   = start_addr[i] + periph_map_pkg::slot_span_c - 1;

        // the range check alone would already pick the window
        assign in_range[i]  = (addr.raw >= start_addr[i]) && (addr.raw <= end_addr[i]);

        // the slot field has to agree, which guards against a map that
        // was edited out of step with the field layout
        assign field_hit[i] = (addr.fields.slot == 3'(i));
    end

    assign match = in_range & field_hit;

    // paddr and psel are held by the requester for the whole transfer,
    // so both outputs stay steady from setup to the last access cycle
    assign slot_sel = psel ? match : '0;

    // an address outside every window is answered by the response mux
    assign unmapped = psel && (match == '0);

    // windows are disjoint, so never more than one slot may answer
    always_comb begin
        assert ($onehot0(slot_sel))
        else $error("address decoder selected more than one slot");
    end

endmodule

// File: apb_reg_slot.sv
/* APB register slot
   three strobed registers, a read-only identity word and fixed wait states */
`timescale 1ns/1ps

module apb_reg_slot #(
    parameter apb_bus_pkg::apb_addr_t slot_base = '0
) (
    input  logic                   clk_i,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_bus_pkg::apb_addr_t paddr,
    input  apb_bus_pkg::apb_data_t pwdata,
    input  apb_bus_pkg::apb_strb_t pstrb,
    output apb_bus_pkg::apb_data_t rdata,
    output logic                   ready,
    output logic                   err
);

    apb_bus_pkg::apb_addr_u addr;

    // the read/write registers of this slot
    apb_bus_pkg::apb_data_t regs [apb_bus_pkg::regs_per_slot_c];

    // counts access cycles spent waiting
    periph_map_pkg::wait_cnt_t wait_cnt;

    logic setup;
    logic access;
    logic idx_rw;
    logic idx_id;
    logic wr_en;
    logic [apb_bus_pkg::reg_sel_width_c-1:0] reg_sel;

    assign addr.raw = paddr;

    // phases as this slot sees them, psel here is the decoded select bit
    assign setup  = psel && !penable;
    assign access = psel && penable;

    // the register index decides between the strobed registers, the
    // identity word and an error response
    assign idx_rw  = addr.fields.reg_idx < apb_bus_pkg::regs_per_slot_c;
    assign idx_id  = addr.fields.reg_idx == apb_bus_pkg::regs_per_slot_c;
    assign reg_sel = addr.fields.reg_idx[apb_bus_pkg::reg_sel_width_c-1:0];

    // ready comes once the wait states of the slot have passed
    assign ready = access && (wait_cnt == periph_map_pkg::wait_cnt_t'(periph_map_pkg::slot_wait_c));

    // offsets past the identity register end the transfer with an error
    assign err = ready && !idx_rw && !idx_id;

    // writes land on the completing edge, never on an erroring transfer
    assign wr_en = ready && pwrite && idx_rw;

    // the counter restarts in every setup phase and after each completion
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (setup || ready) begin
            wait_cnt <= '0;
        end else if (access) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // byte lanes are written only where the strobe is set
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < apb_bus_pkg::regs_per_slot_c; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < apb_bus_pkg::strb_width_c; b++) begin
                if (pstrb[b]) begin
                    regs[reg_sel][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

    // read data is only driven in the completing cycle of a read
    always_comb begin
        rdata = '0;
        if (ready && !pwrite) begin
            if (idx_rw) begin
                rdata = regs[reg_sel];
            end else if (idx_id) begin
                // the identity word reports where this slot lives
                rdata = slot_base;
            end
        end
    end

    // the decoder keeps this slot selected from setup into the access phase
    assert property (@(posedge clk_i) disable iff (!rst_n)
        (psel && penable) |-> $past(psel))
    else $error("slot entered an access phase without its setup phase");

    // the requester holds the address while the slot is inserting wait states
    assert property (@(posedge clk_i) disable iff (!rst_n)
        (access && !ready) |=> $stable(paddr))
    else $error("address changed during a waited access phase");

endmodule

// File: apb_resp_mux.sv
/* APB response multiplexer
   merges the slot responses and answers unmapped addresses with an error */
`timescale 1ns/1ps

module apb_resp_mux (
    input  logic                                               clk_i,
    input  logic                                               rst_n,
    input  logic                                               psel,
    input  logic                                               penable,
    input  logic                                               unmapped,
    input  periph_map_pkg::slot_sel_t                          slot_sel,
    input  apb_bus_pkg::apb_data_t [periph_map_pkg::num_slots_c-1:0] slot_rdata,
    input  periph_map_pkg::slot_sel_t                          slot_ready,
    input  periph_map_pkg::slot_sel_t                          slot_err,
    output apb_bus_pkg::apb_data_t                             prdata,
    output logic                                               pready,
    output logic                                               pslverr
);

    apb_bus_pkg::apb_data_t rdata_acc;
    logic ready_acc;
    logic err_acc;
    logic unmapped_resp;

    // the select is one-hot, so an AND-OR tree picks the addressed slot
    always_comb begin
        rdata_acc = '0;
        ready_acc = 1'b0;
        err_acc   = 1'b0;
        for (int i = 0; i < periph_map_pkg::num_slots_c; i++) begin
            if (slot_sel[i]) begin
                ready_acc = ready_acc | slot_ready[i];
                err_acc   = err_acc | slot_err[i];
                if (slot_ready[i]) begin
                    rdata_acc = rdata_acc | slot_rdata[i];
                end
            end
        end
    end

    // unmapped transfers finish in their first access cycle
    assign unmapped_resp = psel && penable && unmapped;

    // no slot is selected on an unmapped address, so its read data stays zero
    assign prdata  = rdata_acc;
    assign pready  = ready_acc || unmapped_resp;
    assign pslverr = err_acc || unmapped_resp;

    // neither the slots nor the error path may complete outside an access phase
    assert property (@(posedge clk_i) disable iff (!rst_n)
        pready |-> (psel && penable))
    else $error("pready raised outside an access phase");

    // an unmapped setup is followed by an error completion in the next cycle
    assert property (@(posedge clk_i) disable iff (!rst_n)
        (psel && !penable && unmapped) |=> (pready && pslverr))
    else $error("unmapped address was not answered in the first access cycle");

endmodule

// File: periph_bus_top.sv
/* peripheral bus top level
   APB completer built from the decoder, the register slots and the response mux */
`timescale 1ns/1ps

module periph_bus_top (
    input  logic                   clk_i,
    input  logic                   rst_n,
    input  apb_bus_pkg::apb_addr_t paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_bus_pkg::apb_data_t pwdata,
    input  apb_bus_pkg::apb_strb_t pstrb,
    output apb_bus_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr
);

    // decoded select, one bit per slot
    periph_map_pkg::slot_sel_t slot_sel;
    logic unmapped;

    // responses coming back from the slots
    apb_bus_pkg::apb_data_t [periph_map_pkg::num_slots_c-1:0] slot_rdata;
    periph_map_pkg::slot_sel_t slot_ready;
    periph_map_pkg::slot_sel_t slot_err;

    apb_addr_decode u_decode (
        .paddr    (paddr),
        .psel     (psel),
        .slot_sel (slot_sel),
        .unmapped (unmapped)
    );

    // every slot sees the shared bus and only its own select bit,
    // its identity word is the start of its window
    for (genvar i = 0; i < periph_map_pkg::num_slots_c; i++) begin : g_slot
        apb_reg_slot #(
            .slot_base (periph_map_pkg::periph_base_c
                        + apb_bus_pkg::apb_addr_t'(i) * periph_map_pkg::slot_span_c)
        ) u_slot (
            .clk_i   (clk_i),
            .rst_n   (rst_n),
            .psel    (slot_sel[i]),
            .penable (penable),
            .pwrite  (pwrite),
            .paddr   (paddr),
            .pwdata  (pwdata),
            .pstrb   (pstrb),
            .rdata   (slot_rdata[i]),
            .ready   (slot_ready[i]),
            .err     (slot_err[i])
        );
    end

    apb_resp_mux u_resp_mux (
        .clk_i      (clk_i),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .unmapped   (unmapped),
        .slot_sel   (slot_sel),
        .slot_rdata (slot_rdata),
        .slot_ready (slot_ready),
        .slot_err   (slot_err),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

endmodule

// File: tb_periph_bus.sv
/* peripheral bus testbench
   drives APB transfers from a stimulus table and checks data, errors and timing */
`timescale 1ns/1ps

module tb_periph_bus;

    // longest access phase before the run is declared hung
    localparam int ready_timeout_c = 20;

    // one table entry, the test name lives in a queue alongside it
    typedef struct packed {
        logic                   is_write;
        apb_bus_pkg::apb_addr_t addr;
        apb_bus_pkg::apb_data_t wdata;
        apb_bus_pkg::apb_strb_t strb;
        apb_bus_pkg::apb_data_t exp_rdata;
        logic                   exp_err;
        int                     exp_cycles;
    } stim_t;

    logic                   clk_i;
    logic                   rst_n;
    apb_bus_pkg::apb_addr_t paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    apb_bus_pkg::apb_data_t pwdata;
    apb_bus_pkg::apb_strb_t pstrb;
    apb_bus_pkg::apb_data_t prdata;
    logic                   pready;
    logic                   pslverr;

    stim_t stim_q[$];
    string name_q[$];

    // reference copy of every read/write register, updated as the table is built
    apb_bus_pkg::apb_data_t model [periph_map_pkg::num_slots_c][apb_bus_pkg::regs_per_slot_c];

    logic [31:0] lcg_state = 32'h48db61df;

    periph_bus_top dut (
        .clk_i   (clk_i),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #4 clk_i = ~clk_i;

    // numerical recipes constants, good enough for write data
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // only strobed byte lanes take the new data
    function automatic apb_bus_pkg::apb_data_t merge_strobed(input apb_bus_pkg::apb_data_t old_v,
                                                            input apb_bus_pkg::apb_data_t new_v,
                                                            input apb_bus_pkg::apb_strb_t strb);
        apb_bus_pkg::apb_data_t res;
        res = old_v;
        for (int b = 0; b < apb_bus_pkg::strb_width_c; b++) begin
            if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    // window start plus a word offset for the register index
    function automatic apb_bus_pkg::apb_addr_t reg_addr(input int slot, input int idx);
        return periph_map_pkg::periph_base_c
             + apb_bus_pkg::apb_addr_t'(slot) * periph_map_pkg::slot_span_c
             + (apb_bus_pkg::apb_addr_t'(idx) << 2);
    endfunction

    function automatic void add_entry(input string name, input logic is_write,
                                      input apb_bus_pkg::apb_addr_t addr,
                                      input apb_bus_pkg::apb_data_t wdata,
                                      input apb_bus_pkg::apb_strb_t strb,
                                      input apb_bus_pkg::apb_data_t exp_rdata,
                                      input logic exp_err, input int exp_cycles);
        stim_t e;
        e = '{is_write, addr, wdata, strb, exp_rdata, exp_err, exp_cycles};
        stim_q.push_back(e);
        name_q.push_back(name);
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input apb_bus_pkg::apb_data_t exp,
                              input apb_bus_pkg::apb_data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s prdata expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s pslverr expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s pready expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s access cycles expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // one APB transfer, entered and left 1 ns after a rising edge
    task automatic apb_transfer(input string name, input stim_t e,
                                output apb_bus_pkg::apb_data_t rdata, output logic err,
                                output int cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = e.is_write;
        paddr   = e.addr;
        pwdata  = e.wdata;
        pstrb   = e.strb;
        // outputs are combinational, so mid-cycle they have settled
        #2;
        check_ready({name, " setup"}, 1'b0, pready);
        @(posedge clk_i);
        #1;
        penable = 1'b1;
        while (!done) begin
            #2;
            cycles++;
            if (pready) begin
                rdata = prdata;
                err   = pslverr;
                done  = 1'b1;
            end else if (cycles >= ready_timeout_c) begin
                $display("timeout in %s, pready stayed low for %0d access cycles", name, cycles);
                abort_run();
            end
            @(posedge clk_i);
            #1;
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic build_table();
        apb_bus_pkg::apb_data_t d;
        apb_bus_pkg::apb_data_t id;
        int mapped_c;
        int unmapped_c;
        // a mapped slot waits before ready, an unmapped address answers at once
        mapped_c   = periph_map_pkg::slot_wait_c + 1;
        unmapped_c = 1;
        for (int s = 0; s < periph_map_pkg::num_slots_c; s++) begin
            id = reg_addr(s, 0);
            for (int r = 0; r < apb_bus_pkg::regs_per_slot_c; r++) begin
                model[s][r] = '0;
                add_entry($sformatf("reset s%0d r%0d", s, r), 1'b0, reg_addr(s, r), '0, '0,
                          '0, 1'b0, mapped_c);
            end
            add_entry($sformatf("ident s%0d", s), 1'b0, reg_addr(s, 3), '0, '0,
                      id, 1'b0, mapped_c);
        end
        // full writes to one slot, then every register of every slot is read back
        for (int s = 0; s < periph_map_pkg::num_slots_c; s++) begin
            for (int r = 0; r < apb_bus_pkg::regs_per_slot_c; r++) begin
                d = next_random();
                model[s][r] = d;
                add_entry($sformatf("wr s%0d r%0d", s, r), 1'b1, reg_addr(s, r), d, 4'hf,
                          '0, 1'b0, mapped_c);
            end
            for (int t = 0; t < periph_map_pkg::num_slots_c; t++) begin
                for (int r = 0; r < apb_bus_pkg::regs_per_slot_c; r++) begin
                    add_entry($sformatf("rd s%0d r%0d after s%0d", t, r, s), 1'b0,
                              reg_addr(t, r), '0, '0, model[t][r], 1'b0, mapped_c);
                end
            end
        end
        // partial strobes on alternating lanes and then on a single lane
        for (int k = 0; k < 3; k++) begin
            d = next_random();
            model[k+1][2-k] = merge_strobed(model[k+1][2-k], d, apb_bus_pkg::apb_strb_t'(5 << k));
            add_entry($sformatf("strb wr %0d", k), 1'b1, reg_addr(k + 1, 2 - k), d,
                      apb_bus_pkg::apb_strb_t'(5 << k), '0, 1'b0, mapped_c);
            add_entry($sformatf("strb rd %0d", k), 1'b0, reg_addr(k + 1, 2 - k), '0, '0,
                      model[k+1][2-k], 1'b0, mapped_c);
        end
        // the identity word ignores writes
        add_entry("ident wr", 1'b1, reg_addr(4, 3), next_random(), 4'hf, '0, 1'b0, mapped_c);
        add_entry("ident rd", 1'b0, reg_addr(4, 3), '0, '0, reg_addr(4, 0), 1'b0, mapped_c);
        // offsets past the identity word error out and leave the registers alone
        add_entry("bad idx wr", 1'b1, reg_addr(2, 4), next_random(), 4'hf, '0, 1'b1, mapped_c);
        add_entry("bad idx rd", 1'b0, reg_addr(2, 1023), '0, '0, '0, 1'b1, mapped_c);
        for (int r = 0; r < apb_bus_pkg::regs_per_slot_c; r++) begin
            add_entry($sformatf("keep s2 r%0d", r), 1'b0, reg_addr(2, r), '0, '0,
                      model[2][r], 1'b0, mapped_c);
        end
        // empty slot fields and addresses off the peripheral page
        add_entry("unmap slot5", 1'b0, reg_addr(5, 0), '0, '0, '0, 1'b1, unmapped_c);
        add_entry("unmap slot6 wr", 1'b1, reg_addr(6, 1), next_random(), 4'hf,
                  '0, 1'b1, unmapped_c);
        add_entry("unmap slot7", 1'b0, reg_addr(7, 2), '0, '0, '0, 1'b1, unmapped_c);
        add_entry("unmap zero", 1'b0, 32'h0000_0000, '0, '0, '0, 1'b1, unmapped_c);
        add_entry("unmap below", 1'b0, 32'h1A0F_FFFC, '0, '0, '0, 1'b1, unmapped_c);
        add_entry("unmap next page", 1'b0, 32'h1A10_8000, '0, '0, '0, 1'b1, unmapped_c);
    endtask

    initial begin
        apb_bus_pkg::apb_data_t rdata;
        logic err;
        int cycles;
        clk_i   = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        pstrb   = '0;
        build_table();
        repeat (3) @(posedge clk_i);
        #1;
        rst_n = 1'b1;
        @(posedge clk_i);
        #1;
        // transfers run back to back, a new setup follows each completion
        for (int i = 0; i < stim_q.size(); i++) begin
            apb_transfer(name_q[i], stim_q[i], rdata, err, cycles);
            check_err(name_q[i], stim_q[i].exp_err, err);
            if (!stim_q[i].is_write) check_data(name_q[i], stim_q[i].exp_rdata, rdata);
            check_cycles(name_q[i], stim_q[i].exp_cycles, cycles);
        end
        // any failed check has already stopped the run
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: build.f
apb_bus_pkg.sv
periph_map_pkg.sv
apb_addr_decode.sv
apb_reg_slot.sv
apb_resp_mux.sv
periph_bus_top.sv
tb_periph_bus.sv

// File: Makefile
# Verilator build and run of the peripheral bus testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_bus
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       ?= ./$(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS" || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
